/* common/idex_pkg.sv */
`default_nettype none

package idex_pkg;

    // base opcodes of the supported classes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A_RS1  = 2'd0,
        SEL_A_PC   = 2'd1,
        SEL_A_ZERO = 2'd2
    } sel_a_e;

    typedef enum logic [1:0] {
        SEL_B_RS2  = 2'd0,
        SEL_B_IMM  = 2'd1,
        SEL_B_FOUR = 2'd2
    } sel_b_e;

    // msb flags a conditional branch, low bits are its funct3
    typedef enum logic [3:0] {
        BR_NONE   = 4'b0000,
        BR_ALWAYS = 4'b0001,
        BR_EQ     = 4'b1000,
        BR_NE     = 4'b1001,
        BR_LT     = 4'b1100,
        BR_GE     = 4'b1101,
        BR_LTU    = 4'b1110,
        BR_GEU    = 4'b1111
    } br_cond_e;

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        sel_a_e   sel_a;
        sel_b_e   sel_b;
        br_cond_e br_cond;
        logic     jalr;    // target from rs1
        logic     reg_wen;
        logic     mem_rd;
        logic     mem_wr;
        logic     illegal;
        logic [4:0] rd;
    } ctrl_t;

endpackage

`default_nettype wire

/* common/id_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface id_bus_if
    import idex_pkg::*;
#(
    parameter int XLEN = 64
);
    ctrl_t           ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    modport dec_mp (output ctrl);
    modport imm_mp (output imm);

    modport stage_in_mp  (input ctrl, pc, imm, rs1_data, rs2_data);
    modport stage_out_mp (output ctrl, pc, imm, rs1_data, rs2_data);

    modport exe_mp (input ctrl, pc, imm, rs1_data, rs2_data);

endinterface

`default_nettype wire

/* decode/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode
    import idex_pkg::*;
(
    input  wire logic        id_valid_i,
    input  wire logic [31:0] id_instr_i,
    id_bus_if.dec_mp         bus_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       f7_ok;
    alu_op_e    arith_op;
    ctrl_t      ctrl;

    assign opcode = id_instr_i[6:0];
    assign funct3 = id_instr_i[14:12];
    assign funct7 = id_instr_i[31:25];
    assign is_op  = (opcode == OPC_OP);

    // only sub and sra may set bit 30
    assign f7_ok = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_op && id_instr_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = id_instr_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.valid   = id_valid_i;
        ctrl.alu_op  = ALU_ADD;
        ctrl.sel_a   = SEL_A_RS1;
        ctrl.sel_b   = SEL_B_IMM;
        ctrl.br_cond = BR_NONE;
        ctrl.rd      = id_instr_i[11:7];

        case (opcode)
            OPC_OP: begin
                ctrl.alu_op  = arith_op;
                ctrl.sel_b   = SEL_B_RS2;
                ctrl.reg_wen = 1'b1;
                ctrl.illegal = !f7_ok;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op  = arith_op;
                ctrl.reg_wen = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.sel_a   = SEL_A_PC;
                ctrl.reg_wen = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.sel_a   = SEL_A_PC;  // link value pc+4
                ctrl.sel_b   = SEL_B_FOUR;
                ctrl.br_cond = BR_ALWAYS;
                ctrl.jalr    = (opcode == OPC_JALR);
                ctrl.reg_wen = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.sel_a   = SEL_A_PC;
                ctrl.br_cond = br_cond_e'({1'b1, funct3});
            end
            OPC_LOAD: begin
                ctrl.mem_rd  = 1'b1;
                ctrl.reg_wen = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_wr  = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        if (ctrl.illegal) begin
            ctrl.reg_wen = 1'b0;
            ctrl.mem_rd  = 1'b0;
            ctrl.mem_wr  = 1'b0;
            ctrl.br_cond = BR_NONE;
        end
    end

    assign bus_o.ctrl = ctrl;

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import idex_pkg::*;
#(
    parameter int XLEN = 64
)(
    input  wire logic [31:0] id_instr_i,
    id_bus_if.imm_mp         bus_o
);

    logic signed [31:0] imm_i;
    logic signed [31:0] imm_s;
    logic signed [31:0] imm_b;
    logic signed [31:0] imm_u;
    logic signed [31:0] imm_j;
    logic [XLEN-1:0]    imm;

    // all formats keep the sign in bit 31
    assign imm_i = $signed({{20{id_instr_i[31]}}, id_instr_i[31:20]});
    assign imm_s = $signed({{20{id_instr_i[31]}}, id_instr_i[31:25], id_instr_i[11:7]});
    assign imm_b = $signed({{19{id_instr_i[31]}}, id_instr_i[31], id_instr_i[7],
                            id_instr_i[30:25], id_instr_i[11:8], 1'b0});
    assign imm_u = $signed({id_instr_i[31:12], 12'b0});
    assign imm_j = $signed({{11{id_instr_i[31]}}, id_instr_i[31], id_instr_i[19:12],
                            id_instr_i[20], id_instr_i[30:21], 1'b0});

    always_comb begin
        case (id_instr_i[6:0])
            OPC_OP_IMM,
            OPC_LOAD,
            OPC_JALR:   imm = XLEN'(imm_i);
            OPC_STORE:  imm = XLEN'(imm_s);
            OPC_BRANCH: imm = XLEN'(imm_b);
            OPC_LUI,
            OPC_AUIPC:  imm = XLEN'(imm_u);
            OPC_JAL:    imm = XLEN'(imm_j);
            default:    imm = '0;  // no immediate
        endcase
    end

    assign bus_o.imm = imm;

endmodule

`default_nettype wire

/* source/id_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_stage #(
    parameter type payload_t = logic
)(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     bubble_i,
    input  wire logic     flush_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin  // flush wins over bubble
            q_o <= '0;
        end else if (!bubble_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* execute/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec
    import idex_pkg::*;
#(
    parameter int XLEN = 64
)(
    id_bus_if.exe_mp          bus_i,
    output logic [XLEN-1:0]   result_o,
    output logic [XLEN-1:0]   store_data_o,
    output logic              valid_o,
    output logic              reg_wen_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output logic              branch_taken_o,
    output logic              illegal_o,
    output logic [4:0]        rd_o,
    output logic [XLEN-1:0]   target_o
);

    localparam int SHW = $clog2(XLEN);

    ctrl_t           ctrl;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] alu_res;
    logic            taken;
    logic [XLEN-1:0] jalr_sum;

    assign ctrl  = bus_i.ctrl;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (ctrl.sel_a)
            SEL_A_PC:   op_a = bus_i.pc;
            SEL_A_ZERO: op_a = '0;
            default:    op_a = bus_i.rs1_data;
        endcase
        case (ctrl.sel_b)
            SEL_B_IMM:  op_b = bus_i.imm;
            SEL_B_FOUR: op_b = XLEN'(4);
            default:    op_b = bus_i.rs2_data;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = XLEN'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ctrl.br_cond)
            BR_ALWAYS: taken = 1'b1;
            BR_EQ:     taken = (bus_i.rs1_data == bus_i.rs2_data);
            BR_NE:     taken = (bus_i.rs1_data != bus_i.rs2_data);
            BR_LT:     taken = ($signed(bus_i.rs1_data) <  $signed(bus_i.rs2_data));
            BR_GE:     taken = ($signed(bus_i.rs1_data) >= $signed(bus_i.rs2_data));
            BR_LTU:    taken = (bus_i.rs1_data <  bus_i.rs2_data);
            BR_GEU:    taken = (bus_i.rs1_data >= bus_i.rs2_data);
            default:   taken = 1'b0;  // none or reserved funct3
        endcase
    end

    assign jalr_sum = bus_i.rs1_data + bus_i.imm;
    assign target_o = ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : bus_i.pc + bus_i.imm;

    assign result_o     = alu_res;
    assign store_data_o = bus_i.rs2_data;

    assign valid_o        = ctrl.valid;
    assign reg_wen_o      = ctrl.valid & ctrl.reg_wen;
    assign mem_rd_o       = ctrl.valid & ctrl.mem_rd;
    assign mem_wr_o       = ctrl.valid & ctrl.mem_wr;
    assign branch_taken_o = ctrl.valid & taken;
    assign illegal_o      = ctrl.valid & ctrl.illegal;
    assign rd_o           = ctrl.valid ? ctrl.rd : 5'd0;

endmodule

`default_nettype wire

/* source/id_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_top
    import idex_pkg::*;
#(
    parameter int XLEN = 64
)(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            id_valid_i,
    input  wire logic [31:0]     id_instr_i,
    input  wire logic [XLEN-1:0] id_pc_i,
    input  wire logic [XLEN-1:0] id_rs1_data_i,
    input  wire logic [XLEN-1:0] id_rs2_data_i,
    input  wire logic            bubble_i,
    input  wire logic            flush_i,
    output logic                 ex_valid_o,
    output logic [XLEN-1:0]      ex_result_o,
    output logic [4:0]           ex_rd_o,
    output logic                 ex_reg_wen_o,
    output logic                 ex_mem_rd_o,
    output logic                 ex_mem_wr_o,
    output logic [XLEN-1:0]      ex_store_data_o,
    output logic                 ex_branch_taken_o,
    output logic [XLEN-1:0]      ex_target_o,
    output logic                 ex_illegal_o
);

    logic [4*XLEN-1:0] id_data;  // pc, imm, rs1, rs2
    logic [4*XLEN-1:0] ex_data;

    id_bus_if #(.XLEN(XLEN)) id_bus ();
    id_bus_if #(.XLEN(XLEN)) ex_bus ();

    assign id_bus.pc       = id_pc_i;
    assign id_bus.rs1_data = id_rs1_data_i;
    assign id_bus.rs2_data = id_rs2_data_i;

    inst_decode u_inst_decode (
        .id_valid_i (id_valid_i),
        .id_instr_i (id_instr_i),
        .bus_o      (id_bus)
    );

    imm_gen #(.XLEN(XLEN)) u_imm_gen (
        .id_instr_i (id_instr_i),
        .bus_o      (id_bus)
    );

    assign id_data = {id_bus.pc, id_bus.imm, id_bus.rs1_data, id_bus.rs2_data};

    id_ex_stage #(.payload_t(ctrl_t)) u_ctrl_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .bubble_i (bubble_i),
        .flush_i  (flush_i),
        .d_i      (id_bus.ctrl),
        .q_o      (ex_bus.ctrl)
    );

    id_ex_stage #(.payload_t(logic [4*XLEN-1:0])) u_data_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .bubble_i (bubble_i),
        .flush_i  (flush_i),
        .d_i      (id_data),
        .q_o      (ex_data)
    );

    assign {ex_bus.pc, ex_bus.imm, ex_bus.rs1_data, ex_bus.rs2_data} = ex_data;

    alu_exec #(.XLEN(XLEN)) u_alu_exec (
        .bus_i          (ex_bus),
        .result_o       (ex_result_o),
        .store_data_o   (ex_store_data_o),
        .valid_o        (ex_valid_o),
        .reg_wen_o      (ex_reg_wen_o),
        .mem_rd_o       (ex_mem_rd_o),
        .mem_wr_o       (ex_mem_wr_o),
        .branch_taken_o (ex_branch_taken_o),
        .illegal_o      (ex_illegal_o),
        .rd_o           (ex_rd_o),
        .target_o       (ex_target_o)
    );

endmodule

`default_nettype wire

/* verif/id_ex_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_asserts #(
    parameter type payload_t = logic
)(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     bubble_i,
    input  wire logic     flush_i,
    input  wire payload_t d_i,
    input  wire payload_t q_i
);

    int unsigned fail_cnt = 0;

    flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (q_i == '0))
    else begin
        fail_cnt++;
        $error("stage not cleared after flush");
    end

    bubble_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bubble_i && !flush_i) |=> $stable(q_i))
    else begin
        fail_cnt++;
        $error("stage changed during bubble");
    end

    loads_input: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!bubble_i && !flush_i) |=> (q_i == $past(d_i)))
    else begin
        fail_cnt++;
        $error("stage did not load its input");
    end

endmodule

bind id_ex_stage id_ex_asserts #(.payload_t(payload_t)) u_stage_asserts (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .bubble_i (bubble_i),
    .flush_i  (flush_i),
    .d_i      (d_i),
    .q_i      (q_o)
);

`default_nettype wire

/* verif/id_ex_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_checker
    import idex_pkg::*;
#(
    parameter int XLEN = 64
)(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            id_valid_i,
    input  wire logic [31:0]     id_instr_i,
    input  wire logic [XLEN-1:0] id_pc_i,
    input  wire logic [XLEN-1:0] id_rs1_data_i,
    input  wire logic [XLEN-1:0] id_rs2_data_i,
    input  wire logic            bubble_i,
    input  wire logic            flush_i,
    input  wire logic            ex_valid_i,
    input  wire logic [XLEN-1:0] ex_result_i,
    input  wire logic [4:0]      ex_rd_i,
    input  wire logic            ex_reg_wen_i,
    input  wire logic            ex_mem_rd_i,
    input  wire logic            ex_mem_wr_i,
    input  wire logic [XLEN-1:0] ex_store_data_i,
    input  wire logic            ex_branch_taken_i,
    input  wire logic [XLEN-1:0] ex_target_i,
    input  wire logic            ex_illegal_i,
    output int                   err_count_o
);

    localparam int SH = $clog2(XLEN);

    typedef struct packed {
        logic            valid;
        logic            reg_wen;
        logic            mem_rd;
        logic            mem_wr;
        logic            taken;
        logic            illegal;
        logic [4:0]      rd;
        logic            chk_res;   // result defined
        logic            chk_data;  // target and store data defined
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] store_data;
    } exp_t;

    exp_t exp_q = '0;

    initial err_count_o = 0;

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
        return XLEN'($signed(v));
    endfunction

    function automatic logic signed_lt(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);  // sign of a decides
    endfunction

    function automatic logic [XLEN-1:0] arith(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [SH-1:0] sh;
        sh = b[SH-1:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return XLEN'(signed_lt(a, b));
            3'd3:    return XLEN'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ((alt && a[XLEN-1]) ? ~({XLEN{1'b1}} >> sh) : '0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exp_t ref_exec(input logic [31:0] in, input logic vld,
                                      input logic [XLEN-1:0] pc, input logic [XLEN-1:0] rs1,
                                      input logic [XLEN-1:0] rs2);
        exp_t            e;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] imm;
        e          = '0;
        f3         = in[14:12];
        f7         = in[31:25];
        imm        = '0;
        e.chk_res  = 1'b1;
        e.chk_data = 1'b1;
        e.store_data = rs2;
        case (in[6:0])
            OPC_OP: begin
                e.reg_wen = 1'b1;
                e.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                e.result  = arith(f3, in[30], rs1, rs2);
            end
            OPC_OP_IMM: begin
                imm       = sext32({{20{in[31]}}, in[31:20]});
                e.reg_wen = 1'b1;
                e.result  = arith(f3, in[30] && f3 != 3'd0, rs1, imm);
            end
            OPC_LUI, OPC_AUIPC: begin
                imm       = sext32({in[31:12], 12'b0});
                e.reg_wen = 1'b1;
                e.result  = (in[6:0] == OPC_LUI) ? imm : pc + imm;
            end
            OPC_JAL, OPC_JALR: begin
                if (in[6:0] == OPC_JAL)
                    imm = sext32({{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0});
                else
                    imm = sext32({{20{in[31]}}, in[31:20]});
                e.reg_wen = 1'b1;
                e.taken   = 1'b1;
                e.result  = pc + XLEN'(4);  // link address
            end
            OPC_BRANCH: begin
                imm       = sext32({{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0});
                e.chk_res = 1'b0;
                case (f3)
                    3'd0:    e.taken = (rs1 == rs2);
                    3'd1:    e.taken = (rs1 != rs2);
                    3'd4:    e.taken = signed_lt(rs1, rs2);
                    3'd5:    e.taken = !signed_lt(rs1, rs2);
                    3'd6:    e.taken = (rs1 < rs2);
                    3'd7:    e.taken = !(rs1 < rs2);
                    default: e.taken = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                imm       = sext32({{20{in[31]}}, in[31:20]});
                e.mem_rd  = 1'b1;
                e.reg_wen = 1'b1;
                e.result  = rs1 + imm;
            end
            OPC_STORE: begin
                imm      = sext32({{20{in[31]}}, in[31:25], in[11:7]});
                e.mem_wr = 1'b1;
                e.result = rs1 + imm;
            end
            default: e.illegal = 1'b1;
        endcase
        e.target = (in[6:0] == OPC_JALR) ? (rs1 + imm) & ~XLEN'(1) : pc + imm;
        if (!vld) begin
            e = '0;
        end else if (e.illegal) begin
            e.reg_wen  = 1'b0;
            e.chk_res  = 1'b0;
            e.chk_data = 1'b0;
        end
        e.valid = vld;
        e.rd    = vld ? in[11:7] : 5'd0;
        return e;
    endfunction

    task automatic compare_sig(input string name, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
            err_count_o++;
        end
    endtask

    // one edge of latency, flush over bubble
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            exp_q <= '0;
        else if (flush_i)
            exp_q <= '0;
        else if (!bubble_i)
            exp_q <= ref_exec(id_instr_i, id_valid_i, id_pc_i, id_rs1_data_i, id_rs2_data_i);
    end

    always @(negedge clk_i) begin
        compare_sig("ex_valid_o", XLEN'(exp_q.valid), XLEN'(ex_valid_i));
        compare_sig("ex_rd_o", XLEN'(exp_q.rd), XLEN'(ex_rd_i));
        compare_sig("ex_reg_wen_o", XLEN'(exp_q.reg_wen), XLEN'(ex_reg_wen_i));
        compare_sig("ex_mem_rd_o", XLEN'(exp_q.mem_rd), XLEN'(ex_mem_rd_i));
        compare_sig("ex_mem_wr_o", XLEN'(exp_q.mem_wr), XLEN'(ex_mem_wr_i));
        compare_sig("ex_branch_taken_o", XLEN'(exp_q.taken), XLEN'(ex_branch_taken_i));
        compare_sig("ex_illegal_o", XLEN'(exp_q.illegal), XLEN'(ex_illegal_i));
        if (exp_q.chk_data) begin
            compare_sig("ex_target_o", exp_q.target, ex_target_i);
            compare_sig("ex_store_data_o", exp_q.store_data, ex_store_data_i);
        end
        if (exp_q.chk_res)
            compare_sig("ex_result_o", exp_q.result, ex_result_i);
    end

endmodule

`default_nettype wire

/* verif/tb_id_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_ex
    import idex_pkg::*;
();

    localparam int XLEN        = 64;
    localparam int RST_CYCLES  = 4;
    localparam int N_ARITH     = 200;
    localparam int N_FLOW      = 200;
    localparam int N_MEM       = 100;
    localparam int N_ILL       = 60;
    localparam int HOLD_ROUNDS = 4;
    // test bodies plus two drain cycles for each of the six tests
    localparam int TOTAL = RST_CYCLES + 3 + N_ARITH + N_FLOW + N_MEM + HOLD_ROUNDS * 9
                           + N_ILL + 6 * 2;
    localparam int LIMIT = TOTAL * 3 / 2;

    // arith classes first, then control flow, then memory
    localparam logic [6:0] ALL_OPC [9] = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                           OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE};

    logic            clk      = 1'b0;
    logic            rst_n    = 1'b0;
    logic            id_valid = 1'b0;
    logic [31:0]     id_instr = '0;
    logic [XLEN-1:0] id_pc    = '0;
    logic [XLEN-1:0] id_rs1   = '0;
    logic [XLEN-1:0] id_rs2   = '0;
    logic            bubble   = 1'b0;
    logic            flush    = 1'b0;
    logic            ex_valid, ex_reg_wen, ex_mem_rd, ex_mem_wr, ex_taken, ex_illegal;
    logic [4:0]      ex_rd;
    logic [XLEN-1:0] ex_result, ex_store_data, ex_target;
    logic [31:0]     lfsr = 32'h41e9;
    int              err_count;
    int              cycles       = 0;
    int              err_base     = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;

    always #2 clk = ~clk;

    id_ex_top #(.XLEN(XLEN)) DUT (
        .clk_i (clk), .rst_n_i (rst_n), .id_valid_i (id_valid), .id_instr_i (id_instr),
        .id_pc_i (id_pc), .id_rs1_data_i (id_rs1), .id_rs2_data_i (id_rs2),
        .bubble_i (bubble), .flush_i (flush), .ex_valid_o (ex_valid), .ex_result_o (ex_result),
        .ex_rd_o (ex_rd), .ex_reg_wen_o (ex_reg_wen), .ex_mem_rd_o (ex_mem_rd),
        .ex_mem_wr_o (ex_mem_wr), .ex_store_data_o (ex_store_data),
        .ex_branch_taken_o (ex_taken), .ex_target_o (ex_target), .ex_illegal_o (ex_illegal)
    );

    id_ex_checker #(.XLEN(XLEN)) u_checker (
        .clk_i (clk), .rst_n_i (rst_n), .id_valid_i (id_valid), .id_instr_i (id_instr),
        .id_pc_i (id_pc), .id_rs1_data_i (id_rs1), .id_rs2_data_i (id_rs2),
        .bubble_i (bubble), .flush_i (flush), .ex_valid_i (ex_valid), .ex_result_i (ex_result),
        .ex_rd_i (ex_rd), .ex_reg_wen_i (ex_reg_wen), .ex_mem_rd_i (ex_mem_rd),
        .ex_mem_wr_i (ex_mem_wr), .ex_store_data_i (ex_store_data),
        .ex_branch_taken_i (ex_taken), .ex_target_i (ex_target), .ex_illegal_i (ex_illegal),
        .err_count_o (err_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_supported(input logic [6:0] opc);
        foreach (ALL_OPC[i])
            if (ALL_OPC[i] == opc) return 1'b1;
        return 1'b0;
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] opc);
        logic [31:0] in;
        in = {25'(rand_bits(25)), opc};
        case (opc)
            OPC_OP: begin
                in[31:25] = {1'b0, in[30], 5'b0};
                if (in[14:12] != 3'd0 && in[14:12] != 3'd5) in[30] = 1'b0;
            end
            OPC_OP_IMM: if (in[13:12] == 2'b01) in[31:26] = {1'b0, in[30] & in[14], 4'b0};
            OPC_BRANCH: in[14] = in[14] | in[13];  // skip reserved funct3
            OPC_JALR:   in[14:12] = 3'd0;
            OPC_STORE:  in[14] = 1'b0;
            default: ;
        endcase
        return in;
    endfunction

    function automatic logic [31:0] any_instr();
        return make_instr(ALL_OPC[rand_bits(4) % 9]);
    endfunction

    function automatic logic [31:0] bad_op();
        logic [31:0] in;
        in        = make_instr(OPC_OP);
        in[31:25] = 7'(rand_bits(7));
        if (in[31:25] == 7'h00 || in[31:25] == 7'h20) in[31:25] = 7'h01;
        return in;
    endfunction

    function automatic logic [31:0] bad_opcode();
        logic [6:0] opc;
        opc = 7'(rand_bits(7));
        while (is_supported(opc)) opc = 7'(rand_bits(7));
        return {25'(rand_bits(25)), opc};
    endfunction

    function automatic int total_errs();
        return err_count + int'(DUT.u_ctrl_stage.u_stage_asserts.fail_cnt)
               + int'(DUT.u_data_stage.u_stage_asserts.fail_cnt);
    endfunction

    task automatic drive(input logic vld, input logic [31:0] in, input logic bub,
                         input logic fl);
        @(posedge clk);
        #0.5;
        id_valid = vld;
        id_instr = in;
        id_pc    = XLEN'(rand_bits(XLEN - 2) << 2);
        id_rs1   = rand_bits(XLEN);
        id_rs2   = (rand_bits(2) == 0) ? id_rs1 : rand_bits(XLEN);  // equal operands now and then
        bubble   = bub;
        flush    = fl;
    endtask

    task automatic end_test(input string name);
        int errs;
        drive(1'b0, 32'h0, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 1'b0, 1'b0);
        errs = total_errs() - err_base;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
        err_base = total_errs();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        repeat (RST_CYCLES) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        repeat (2) drive(1'b0, any_instr(), 1'b0, 1'b0);  // no valid word yet
        end_test("reset");
        repeat (N_ARITH) drive(1'b1, make_instr(ALL_OPC[rand_bits(2)]), 1'b0, 1'b0);
        end_test("arith");
        repeat (N_FLOW) drive(1'b1, make_instr(ALL_OPC[4 + rand_bits(2) % 3]), 1'b0, 1'b0);
        end_test("control_flow");
        repeat (N_MEM) drive(1'b1, make_instr(ALL_OPC[7 + rand_bits(1)]), 1'b0, 1'b0);
        end_test("memory");
        repeat (HOLD_ROUNDS) begin
            drive(1'b1, any_instr(), 1'b0, 1'b0);
            repeat (5) drive(1'b1, any_instr(), 1'b1, 1'b0);
            drive(1'b1, any_instr(), 1'b1, 1'b1);  // flush beats bubble
            drive(1'b1, any_instr(), 1'b0, 1'b0);
            drive(1'b1, any_instr(), 1'b0, 1'b1);
        end
        end_test("hold_flush");
        for (int i = 0; i < N_ILL; i++)
            drive(1'b1, i[0] ? bad_op() : bad_opcode(), 1'b0, 1'b0);
        end_test("illegal");
        $display("summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, total_errs());
        if (tests_failed == 0 && total_errs() == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
common/idex_pkg.sv
common/id_bus_if.sv
decode/inst_decode.sv
decode/imm_gen.sv
source/id_ex_stage.sv
execute/alu_exec.sv
source/id_ex_top.sv
verif/id_ex_asserts.sv
verif/id_ex_checker.sv
verif/tb_id_ex.sv
